// ==== design/axi_lite_pkg.sv ====
`default_nettype none

// AXI4-Lite channel payloads shared by master and slave
package axi_lite_pkg;

    // response codes, only the two the SRAM can give
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } axi_ar;   // read address, 33 bits

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        resp_e       resp;
    } axi_r;    // read data, 35 bits

    // write address and data travel together
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_aw_w;

    typedef struct packed {
        logic  valid;
        resp_e resp;
    } axi_b;    // write response

endpackage

`default_nettype wire

// ==== design/fetch_pkg.sv ====
`default_nettype none

// types used by the fetch front end
package fetch_pkg;

    // one slot of the instruction queue
    typedef struct packed {
        logic [31:0] pc;     // address the word came from
        logic [31:0] inst;   // raw instruction, zero on fault
        logic        fault;  // bus error on the fetch
    } fetch_entry;           // 65 bits

    // fetch FSM
    typedef enum logic [1:0] {
        idle      = 2'd0,    // waiting for run and queue room
        addr      = 2'd1,    // arvalid held high
        wait_data = 2'd2     // rready held high
    } fetch_state_e;

    // major opcodes seen by the pre-decode
    // everything not listed maps to other
    typedef enum logic [6:0] {
        other = 7'b0000000,
        jal   = 7'b1101111
    } opcode_e;

    // J-type immediate layout
    //   inst[31]    imm[20]
    //   inst[30:21] imm[10:1]
    //   inst[20]    imm[11]
    //   inst[19:12] imm[19:12]
    // imm[0] is always zero

endpackage

`default_nettype wire

// ==== design/inst_sram.sv ====
`timescale 1ns/10ps
`default_nettype none

// instruction memory behind an AXI4-Lite slave port
// reads come back after a fixed number of cycles
module inst_sram #(
    parameter logic [31:0] reset_pc     = 32'h8000_0000,  // base address
    parameter int          mem_words    = 256,
    parameter int          sram_latency = 2               // 1 to 4
) (
    input  wire                   clk,
    input  wire                   rst,
    input  axi_lite_pkg::axi_ar   ar,
    output logic                  arready,
    output axi_lite_pkg::axi_r    r,
    input  wire                   rready,
    input  axi_lite_pkg::axi_aw_w aw_w,
    output logic                  aw_w_ready,
    output axi_lite_pkg::axi_b    b,
    input  wire                   bready
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = $clog2(sram_latency + 1);

    logic [31:0] mem [mem_words];

    logic [31:0]         raddr;      // latched on AR handshake
    logic                pending;    // read counting down
    logic [cnt_w-1:0]    cnt;
    logic                rvalid_q;
    logic [31:0]         rdata_q;
    axi_lite_pkg::resp_e rresp_q;
    logic                bvalid_q;
    axi_lite_pkg::resp_e bresp_q;

    logic ar_hs;
    logic r_hs;
    logic w_hs;
    logic fire;  // counter expired, present the word

    // word aligned and inside the array
    function automatic logic addr_ok(input logic [31:0] a);
        logic [31:0] off;
        off = a - reset_pc;
        return (a[1:0] == 2'b00) && (off < 32'(mem_words) * 32'd4);
    endfunction

    function automatic logic [idx_w-1:0] word_idx(input logic [31:0] a);
        logic [31:0] off;
        off = a - reset_pc;
        return off[idx_w+1:2];
    endfunction

    assign ar_hs = ar.valid && arready;
    assign r_hs  = rvalid_q && rready;
    assign fire  = pending && (cnt == '0);

    // ready follows valid, blocked while a b response waits
    assign aw_w_ready = aw_w.valid && !bvalid_q;
    assign w_hs       = aw_w_ready;

    assign r = '{valid: rvalid_q, data: rdata_q, resp: rresp_q};
    assign b = '{valid: bvalid_q, resp: bresp_q};

    // read control
    always_ff @(posedge clk) begin
        if (rst) begin
            arready  <= 1'b1;
            pending  <= 1'b0;
            cnt      <= '0;
            rvalid_q <= 1'b0;
        end else begin
            if (ar_hs) begin
                arready <= 1'b0;                         // one read at a time
                pending <= 1'b1;
                cnt     <= cnt_w'(sram_latency - 1);
            end else if (fire) begin
                pending  <= 1'b0;
                rvalid_q <= 1'b1;                         // held until rready
            end else if (pending) begin
                cnt <= cnt - 1'b1;
            end
            if (r_hs) begin
                rvalid_q <= 1'b0;
                arready  <= 1'b1;                         // free for the next read
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            raddr <= ar.addr;
        end
        if (fire) begin
            if (addr_ok(raddr)) begin
                rdata_q <= mem[word_idx(raddr)];
                rresp_q <= axi_lite_pkg::OKAY;
            end else begin
                rdata_q <= 32'h0;                         // bad address reads zero
                rresp_q <= axi_lite_pkg::SLVERR;
            end
        end
    end

    // write response
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (w_hs) begin
            bvalid_q <= 1'b1;
        end else if (bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // program load with byte strobes
    always_ff @(posedge clk) begin
        if (w_hs) begin
            if (addr_ok(aw_w.addr)) begin
                for (int i = 0; i < 4; i++) begin
                    if (aw_w.strb[i]) begin
                        mem[word_idx(aw_w.addr)][i*8 +: 8] <= aw_w.data[i*8 +: 8];
                    end
                end
                bresp_q <= axi_lite_pkg::OKAY;
            end else begin
                bresp_q <= axi_lite_pkg::SLVERR;          // write dropped
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

// pc sequencing and AXI4-Lite read master for instruction fetch
module fetch_unit #(
    parameter logic [31:0] reset_pc = 32'h8000_0000
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      run,
    input  wire                      redirect_valid,
    input  wire  [31:0]              redirect_pc,
    output axi_lite_pkg::axi_ar      ar,
    input  wire                      arready,
    input  axi_lite_pkg::axi_r       r,
    output logic                     rready,
    output logic                     push,
    output fetch_pkg::fetch_entry    entry,
    input  wire                      space,
    output logic                     flush
);

    fetch_pkg::fetch_state_e state;

    logic [31:0] pc;       // pc of the word being fetched
    logic [31:0] ar_addr;  // stays put while arvalid waits
    logic        drop;     // outstanding read was cancelled

    logic            r_hs;
    logic            fault;
    fetch_pkg::opcode_e op;
    logic [31:0]     j_imm;
    logic [31:0]     next_pc;   // sequential or jal target
    logic [31:0]     issue_pc;  // address of the next AR after a response

    assign ar     = '{valid: (state == fetch_pkg::addr), addr: ar_addr};
    assign rready = (state == fetch_pkg::wait_data);
    assign r_hs   = r.valid && rready;
    assign flush  = redirect_valid;  // queue cleared in the same cycle

    // pre-decode of the returning word
    always_comb begin
        fault = (r.resp == axi_lite_pkg::SLVERR);
        op    = (r.data[6:0] == fetch_pkg::jal) ? fetch_pkg::jal : fetch_pkg::other;
        j_imm = {{12{r.data[31]}}, r.data[19:12], r.data[20], r.data[30:21], 1'b0};
        if (!fault && op == fetch_pkg::jal) begin
            next_pc = pc + j_imm;   // static jump
        end else begin
            next_pc = pc + 32'd4;   // faults keep stepping too
        end
        if (redirect_valid) begin
            issue_pc = redirect_pc;
        end else if (drop) begin
            issue_pc = pc;          // pc already holds the redirect target
        end else begin
            issue_pc = next_pc;
        end
    end

    // a stale or redirected response never reaches the queue
    assign push  = r_hs && !drop && !redirect_valid;
    assign entry = '{pc: pc, inst: r.data, fault: fault};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::idle;
            pc    <= reset_pc;
            drop  <= 1'b0;
        end else begin
            case (state)
                fetch_pkg::idle: begin
                    if (redirect_valid) begin
                        pc <= redirect_pc;             // start there next cycle
                    end else if (run && space) begin
                        state <= fetch_pkg::addr;
                    end
                end
                fetch_pkg::addr: begin
                    if (arready) begin
                        state <= fetch_pkg::wait_data;
                    end
                    if (redirect_valid) begin
                        pc   <= redirect_pc;
                        drop <= 1'b1;                  // AR already on the bus
                    end
                end
                fetch_pkg::wait_data: begin
                    if (r_hs) begin
                        drop <= 1'b0;
                        pc   <= issue_pc;
                        if (run && space) begin
                            state <= fetch_pkg::addr;  // back to back
                        end else begin
                            state <= fetch_pkg::idle;
                        end
                    end else if (redirect_valid) begin
                        pc   <= redirect_pc;
                        drop <= 1'b1;                  // wait and discard
                    end
                end
                default: state <= fetch_pkg::idle;
            endcase
        end
    end

    // AR address register
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::idle && !redirect_valid) begin
            ar_addr <= pc;
        end else if (r_hs) begin
            ar_addr <= issue_pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/inst_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

// circular buffer of fetch entries toward decode
module inst_queue #(
    parameter int queue_depth = 4   // power of two, at least 2
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      flush,
    input  wire                      push,
    input  fetch_pkg::fetch_entry    entry,
    output logic                     space,
    output logic                     inst_valid,
    output fetch_pkg::fetch_entry    inst,
    input  wire                      inst_ready
);

    localparam int ptr_w = $clog2(queue_depth);

    fetch_pkg::fetch_entry slots [queue_depth];

    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0]   count;   // one extra bit for full
    logic             pop;

    assign inst_valid = (count != '0);
    assign inst       = slots[rd_ptr];
    assign pop        = inst_valid && inst_ready;

    // room for one more word beyond the read in flight
    assign space = (count + 1'b1) < (ptr_w + 1)'(queue_depth);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;            // flush drops everything
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= entry;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

// fetch front end: fetch unit, instruction SRAM and queue
module fetch_top #(
    parameter logic [31:0] reset_pc     = 32'h8000_0000,
    parameter int          mem_words    = 256,
    parameter int          sram_latency = 2,
    parameter int          queue_depth  = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      run,
    input  wire                      redirect_valid,
    input  wire  [31:0]              redirect_pc,
    input  axi_lite_pkg::axi_aw_w    aw_w,         // program load port
    output logic                     aw_w_ready,
    output axi_lite_pkg::axi_b       b,
    input  wire                      bready,
    output logic                     inst_valid,   // toward decode
    output fetch_pkg::fetch_entry    inst,
    input  wire                      inst_ready
);

    axi_lite_pkg::axi_ar   ar;
    logic                  arready;
    axi_lite_pkg::axi_r    r;
    logic                  rready;
    logic                  push;
    fetch_pkg::fetch_entry entry;
    logic                  space;
    logic                  flush;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk, .rst, .run, .redirect_valid, .redirect_pc,
        .ar, .arready, .r, .rready,
        .push, .entry, .space, .flush
    );

    inst_sram #(
        .reset_pc     (reset_pc),
        .mem_words    (mem_words),
        .sram_latency (sram_latency)
    ) u_sram (
        .clk, .rst, .ar, .arready, .r, .rready,
        .aw_w, .aw_w_ready, .b, .bready
    );

    inst_queue #(
        .queue_depth (queue_depth)
    ) u_queue (
        .clk, .rst, .flush, .push, .entry, .space,
        .inst_valid, .inst, .inst_ready
    );

endmodule

`default_nettype wire

// ==== testbench/fetch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

// handshake assertions, bound into fetch_top
module fetch_checker #(
    parameter int sram_latency = 2
) (
    input wire                  clk,
    input wire                  rst,
    input axi_lite_pkg::axi_ar  ar,
    input wire                  arready,
    input axi_lite_pkg::axi_r   r,
    input wire                  rready,
    input wire                  inst_valid,
    input wire                  redirect_valid
);

    int   since_ar;      // cycles since the last AR handshake
    logic outstanding;   // AR accepted, R not yet taken

    always_ff @(posedge clk) begin
        if (rst) begin
            since_ar    <= 0;
            outstanding <= 1'b0;
        end else begin
            if (ar.valid && arready) begin
                since_ar    <= 0;
                outstanding <= 1'b1;
            end else if (since_ar < 1000) begin
                since_ar <= since_ar + 1;   // saturates
            end
            if (r.valid && rready) begin
                outstanding <= 1'b0;
            end
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (rst)
        (ar.valid && !arready) |=> $stable(ar))
        else $error("AR payload changed while stalled");

    r_stable: assert property (@(posedge clk) disable iff (rst)
        (r.valid && !rready) |=> $stable(r))
        else $error("R payload changed while stalled");

    // read data only answers a request
    r_after_ar: assert property (@(posedge clk) disable iff (rst)
        $rose(r.valid) |-> outstanding)
        else $error("rvalid rose with no read outstanding");

    r_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(r.valid) |-> (since_ar == sram_latency))
        else $error("rvalid came at the wrong read latency");

    flush_empty: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |=> !inst_valid)
        else $error("queue not empty after redirect");

endmodule

`default_nettype wire

// ==== testbench/tb_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fetch;

    localparam logic [31:0] base      = 32'h8000_0000;
    localparam int          words     = 256;
    localparam int          lat       = 2;     // default sram_latency
    localparam int          n_entries = 98;    // sum over all collect calls
    localparam int          n_loads   = 320;
    localparam int          limit     = n_entries * (lat + 6) * 2 + n_loads * 4 + 400;

    logic                  clk;
    logic                  rst;
    logic                  run;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    axi_lite_pkg::axi_aw_w aw_w;
    logic                  aw_w_ready;
    axi_lite_pkg::axi_b    b;
    logic                  bready;
    logic                  inst_valid;
    fetch_pkg::fetch_entry inst;
    logic                  inst_ready;

    logic [31:0] img [words];       // model copy of the SRAM
    logic [31:0] jump_off [words];  // byte offset of each jal, zero elsewhere
    logic [31:0] exp_pc;            // model pc
    logic [31:0] rng;
    int          errors;

    fetch_top u_dut (
        .clk, .rst, .run, .redirect_valid, .redirect_pc,
        .aw_w, .aw_w_ready, .b, .bready,
        .inst_valid, .inst, .inst_ready
    );

    bind fetch_top fetch_checker #(.sram_latency(sram_latency)) u_checker (
        .clk, .rst, .ar, .arready, .r, .rready, .inst_valid, .redirect_valid
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        $display("Something failed");
        $fatal(1, "stopped on error");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped on mismatch");
        end
    endtask

    // word aligned and inside the array
    function automatic logic in_range(input logic [31:0] a);
        return a >= base && a < base + 32'(words * 4) && a[1:0] == 2'b00;
    endfunction

    function automatic logic [31:0] encode_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    // random word that is never a jal
    function automatic logic [31:0] plain_word();
        logic [31:0] w;
        w = xorshift();
        if (w[6:0] == 7'b1101111) begin
            w[6:0] = 7'b0010011;   // make it an addi
        end
        return w;
    endfunction

    task automatic load_word(input logic [31:0] a, input logic [31:0] d);
        int t;
        @(negedge clk);
        aw_w = '{valid: 1'b1, addr: a, data: d, strb: 4'hf};
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > 20) begin
                report_failure("write response never came back");
            end
        end while (!b.valid);
        check("aw_w_ready", 64'(aw_w_ready), 64'd0);   // held off while b is pending
        aw_w.valid = 1'b0;
        check("bresp", 64'(b.resp), 64'(axi_lite_pkg::OKAY));
        img[(a - base) >> 2]      = d;
        jump_off[(a - base) >> 2] = 32'h0;
    endtask

    // redirect pulse, model restarts at pc
    task automatic restart(input logic [31:0] pc);
        @(negedge clk);
        inst_ready     = 1'b0;
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
        check("inst_valid after redirect", 64'(inst_valid), 64'd0);
        exp_pc = pc;
    endtask

    // pop n entries and compare each with the model
    task automatic collect(input int n, input bit stall);
        int          got;
        logic [31:0] w;
        logic [31:0] rnd;
        logic        f;
        got = 0;
        while (got < n) begin
            @(negedge clk);
            rnd        = xorshift();
            inst_ready = stall ? rnd[3] : 1'b1;   // about half stalled
            if (inst_valid && inst_ready) begin
                f = !in_range(exp_pc);
                w = f ? 32'h0 : img[(exp_pc - base) >> 2];
                check("inst.pc", 64'(inst.pc), 64'(exp_pc));
                check("inst.inst", 64'(inst.inst), 64'(w));
                check("inst.fault", 64'(inst.fault), 64'(f));
                if (!f && w[6:0] == 7'b1101111) begin
                    exp_pc = exp_pc + jump_off[(exp_pc - base) >> 2];   // jal taken statically
                end else begin
                    exp_pc = exp_pc + 32'd4;
                end
                got++;
            end
        end
    endtask

    task automatic test_sequential();
        for (int i = 0; i < words; i++) begin
            load_word(base + 32'(i * 4), plain_word());
        end
        @(negedge clk);
        run    = 1'b1;   // fetch from reset_pc
        exp_pc = base;
        collect(24, 1'b0);
    endtask

    task automatic test_jal();
        logic [31:0] w;
        int          offw;
        bit          is_jal;
        for (int i = 64; i < 128; i++) begin
            w = xorshift();
            is_jal = (w[1:0] == 2'b00);
            if (is_jal) begin
                offw = int'(w[8:4]) - 16;      // -16..15 words
                w    = encode_jal(21'(offw * 4));
            end else begin
                w = plain_word();
            end
            load_word(base + 32'(i * 4), w);
            if (is_jal) begin
                jump_off[i] = 32'(offw * 4);   // offset as generated
            end
        end
        restart(base + 32'h100);
        collect(24, 1'b0);
    endtask

    task automatic test_backpressure();
        restart(base);
        collect(24, 1'b1);   // random inst_ready
    endtask

    task automatic test_redirect();
        restart(base + 32'h20);
        collect(6, 1'b0);
        restart(base + 32'h200);   // mid-stream, queue flushed
        collect(10, 1'b0);
    endtask

    task automatic test_fault();
        restart(base + 32'(words * 4) - 32'd8);   // last two words, then off the end
        collect(6, 1'b0);
    endtask

    // latency itself is checked by the bound r_latency assertion
    task automatic test_latency();
        restart(base);
        collect(4, 1'b0);
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        run            = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = 32'h0;
        aw_w           = '0;
        bready         = 1'b1;   // write responses taken at once
        inst_ready     = 1'b0;
        rng            = 32'hcfb6;
        errors         = 0;
        exp_pc         = base;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        test_sequential();
        test_jal();
        test_backpressure();
        test_redirect();
        test_fault();
        test_latency();

        @(negedge clk);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog sized from entry and load counts
    initial begin
        repeat (limit) @(posedge clk);
        $display("timeout: the tests did not finish in %0d cycles", limit);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/axi_lite_pkg.sv
design/fetch_pkg.sv
design/inst_sram.sv
design/fetch_unit.sv
design/inst_queue.sv
design/fetch_top.sv
testbench/fetch_checker.sv
testbench/tb_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch -f all.f -o tb_fetch_sim \
    && ./obj_dir/tb_fetch_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
